// File: include/ddrTiming_cfg.svh
/*
  DDR2 command core limits. All timing values count CLK cycles
  (one CLK is two memory clocks) and must be at least 1.
  DDR_RANK_W has to hold DDR_RANKS - 1. DDR_T_RFC is the longest rank timer.
*/
`ifndef DDR_TIMING_CFG_SVH
`define DDR_TIMING_CFG_SVH

// ----------------------------------------
// address fields
`define DDR_ROW_W       14      // 16K rows
`define DDR_BANK_W      3       // 8 banks
`define DDR_COL_W       8       // 4 columns per access
`define DDR_RANKS       2
`define DDR_RANK_W      1
`define DDR_REQ_W       (1 + `DDR_RANK_W + `DDR_ROW_W + `DDR_BANK_W + `DDR_COL_W)

`define DDR_FIFO_DEPTH  8

// ----------------------------------------
// spacing rules
`define DDR_T_RTW       2       // read to write
`define DDR_T_WTR       5       // write to read
`define DDR_T_RPA       3       // precharge period
`define DDR_T_RTP       3       // read to precharge
`define DDR_T_WTP       6       // write to precharge
`define DDR_T_RAS       6       // activate to precharge
`define DDR_T_RFC       17      // refresh to activate
`define DDR_T_FAW       5       // activate window length
`define DDR_FAW_ACTS    4       // activates per window

`endif

// File: src/ddrPkg.sv
/*
  Shared types of the DDR2 command core. Command codes are the
  RAS, CAS, WE pin levels, active low.
*/
`default_nettype none

`include "ddrTiming_cfg.svh"

package ddrPkg;

   // RAS CAS WE
   typedef enum logic [2:0] {
      cmdRefresh   = 3'b001,
      cmdPrecharge = 3'b010,
      cmdActivate  = 3'b011,
      cmdWrite     = 3'b100,
      cmdRead      = 3'b101,
      cmdNop       = 3'b111
   } ddrCmdT;

   // field order matches the queue word, read flag on top
   typedef struct packed {
      logic                   read;
      logic [`DDR_RANK_W-1:0] rank;
      logic [`DDR_ROW_W-1:0]  row;
      logic [`DDR_BANK_W-1:0] bank;
      logic [`DDR_COL_W-1:0]  col;
   } ddrReqT;

   typedef enum logic [1:0] {
      accHit      = 2'd0,   // row already open
      accMiss     = 2'd1,   // bank idle
      accConflict = 2'd2    // other row open
   } accessClassT;

endpackage

`default_nettype wire

// File: src/reqFifo.sv
/*
  Request queue. Pushes while full and pops while empty are dropped.
  The head word is valid whenever empty is low.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module reqFifo (
   input  logic                  CLK,
   input  logic                  arstN,
   input  logic                  push,
   input  logic [`DDR_REQ_W-1:0] wrData,
   input  logic                  pop,
   output logic [`DDR_REQ_W-1:0] rdData,
   output logic                  empty,
   output logic                  full
);

   localparam int Depth = `DDR_FIFO_DEPTH;
   localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
   localparam int CntW  = $clog2(Depth + 1);

   logic [`DDR_REQ_W-1:0] mem [Depth];
   logic [PtrW-1:0]       wrPtr;
   logic [PtrW-1:0]       rdPtr;
   logic [CntW-1:0]       count;
   logic                  doPush;
   logic                  doPop;

   assign doPush = push & ~full;
   assign doPop  = pop & ~empty;
   assign empty  = (count == '0);
   assign full   = (count == CntW'(Depth));
   assign rdData = mem[rdPtr];     // head always shown

   always_ff @(posedge CLK) begin
      if (doPush) mem[wrPtr] <= wrData;
   end

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop) rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
         if (doPush & ~doPop) count <= count + 1'b1;
         else if (doPop & ~doPush) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/openBankTable.sv
/*
  Open-row table, one entry per rank and bank. A lookup classifies the
  request and marks its row open in the same edge, before any command
  issues. clearRank closes every bank of one rank after a refresh.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module openBankTable import ddrPkg::*; (
   input  logic                   CLK,
   input  logic                   arstN,
   input  logic                   lookup,
   input  ddrReqT                 req,
   input  logic                   clearRank,
   input  logic [`DDR_RANK_W-1:0] clearRankSel,
   output accessClassT            reqClass
);

   localparam int Banks = 2 ** `DDR_BANK_W;

   logic [Banks-1:0]      openFlag [`DDR_RANKS];
   logic [`DDR_ROW_W-1:0] openRow  [`DDR_RANKS][Banks];
   logic                  bankOpen;
   logic                  rowMatch;
   accessClassT           classNow;

   assign bankOpen = openFlag[req.rank][req.bank];
   assign rowMatch = (openRow[req.rank][req.bank] == req.row);

   always_comb begin
      if (!bankOpen) classNow = accMiss;
      else if (rowMatch) classNow = accHit;
      else classNow = accConflict;
   end

   // ----------------------------------------
   // flags and class
   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         for (int r = 0; r < `DDR_RANKS; r++) begin
            openFlag[r] <= '0;
         end
         reqClass <= accMiss;
      end else begin
         if (clearRank) openFlag[clearRankSel] <= '0;   // refresh closes the rank
         if (lookup) begin
            reqClass                   <= classNow;
            openFlag[req.rank][req.bank] <= 1'b1;     // speculative open
         end
      end
   end

   // row store
   always_ff @(posedge CLK) begin
      if (lookup) openRow[req.rank][req.bank] <= req.row;
   end

endmodule

`default_nettype wire

// File: src/rankTimers.sv
/*
  Per-rank down-counters for activate, read, write and refresh spacing,
  plus the four-activate window. Counters load on the issue edge and
  block until they reach zero. Results are reported for queryRank.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module rankTimers import ddrPkg::*; (
   input  logic                   CLK,
   input  logic                   arstN,
   input  logic                   actRank,
   input  logic [`DDR_RANK_W-1:0] actSel,
   input  logic [`DDR_RANK_W-1:0] readSel,
   input  logic [`DDR_RANK_W-1:0] writeSel,
   input  logic                   readGo,
   input  logic                   writeGo,
   input  logic                   refreshGo,
   input  logic [`DDR_RANK_W-1:0] refreshSel,
   input  logic [`DDR_RANK_W-1:0] queryRank,
   output logic                   prechargeBlock,
   output logic                   refreshBusy,
   output logic                   fawBlock
);

   localparam int RankW  = `DDR_RANK_W;
   localparam int NumT   = 4;                    // act, read, write, refresh
   localparam int CntW   = $clog2(`DDR_T_RFC + 1);
   localparam int FawCntW = $clog2(`DDR_FAW_ACTS + 1);
   localparam logic [NumT-1:0][CntW-1:0] LoadVal = {
      CntW'(`DDR_T_RFC), CntW'(`DDR_T_WTP), CntW'(`DDR_T_RTP), CntW'(`DDR_T_RAS)};

   logic [CntW-1:0]      cnt      [`DDR_RANKS][NumT];
   logic                 zeroFlag [`DDR_RANKS][NumT];
   logic [NumT-1:0]      load     [`DDR_RANKS];
   logic [`DDR_T_FAW-1:0] fawWin  [`DDR_RANKS];
   logic [FawCntW-1:0]   actCnt   [`DDR_RANKS];
   logic                 fawFull  [`DDR_RANKS];

   for (genvar r = 0; r < `DDR_RANKS; r++) begin : gRank
      assign load[r] = {refreshGo & (refreshSel == RankW'(r)),
                        writeGo & (writeSel == RankW'(r)),
                        readGo & (readSel == RankW'(r)),
                        actRank & (actSel == RankW'(r))};

      for (genvar t = 0; t < NumT; t++) begin : gTimer
         always_ff @(posedge CLK or negedge arstN) begin
            if (!arstN) begin
               cnt[r][t]      <= '0;
               zeroFlag[r][t] <= 1'b1;
            end else if (load[r][t]) begin
               cnt[r][t]      <= LoadVal[t];
               zeroFlag[r][t] <= 1'b0;
            end else if (!zeroFlag[r][t]) begin
               cnt[r][t]      <= cnt[r][t] - 1'b1;
               zeroFlag[r][t] <= (cnt[r][t] == CntW'(1));   // sticks at zero
            end
         end
      end

      // ----------------------------------------
      // activate window, one slot per cycle
      always_ff @(posedge CLK or negedge arstN) begin
         if (!arstN) begin
            fawWin[r] <= '0;
            actCnt[r] <= '0;
         end else begin
            fawWin[r] <= {load[r][0], fawWin[r][`DDR_T_FAW-1:1]};
            actCnt[r] <= actCnt[r] + FawCntW'(load[r][0]) - FawCntW'(fawWin[r][0]);
         end
      end

      assign fawFull[r] = (actCnt[r] == FawCntW'(`DDR_FAW_ACTS));
   end

   assign prechargeBlock = ~(zeroFlag[queryRank][0] & zeroFlag[queryRank][1] &
                             zeroFlag[queryRank][2]);
   assign refreshBusy    = ~zeroFlag[queryRank][3];
   assign fawBlock       = fawFull[queryRank];

endmodule

`default_nettype wire

// File: src/busTurnTimers.sv
/*
  Shared data-bus turnaround and precharge-period timers. A counter
  reloads on its issue edge and blocks while it is non-zero.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module busTurnTimers import ddrPkg::*; (
   input  logic CLK,
   input  logic arstN,
   input  logic readGo,
   input  logic writeGo,
   input  logic prechargeGo,
   output logic readBlock,
   output logic writeBlock,
   output logic precharging
);

   localparam int NumT = 3;                      // wtr, rtw, rpa
   localparam int MaxA = (`DDR_T_WTR > `DDR_T_RTW) ? `DDR_T_WTR : `DDR_T_RTW;
   localparam int MaxT = (MaxA > `DDR_T_RPA) ? MaxA : `DDR_T_RPA;
   localparam int CntW = $clog2(MaxT + 1);
   localparam logic [NumT-1:0][CntW-1:0] LoadVal = {
      CntW'(`DDR_T_RPA), CntW'(`DDR_T_RTW), CntW'(`DDR_T_WTR)};

   logic [CntW-1:0] cnt      [NumT];
   logic            zeroFlag [NumT];
   logic [NumT-1:0] load;

   assign load = {prechargeGo, readGo, writeGo};

   for (genvar t = 0; t < NumT; t++) begin : gTimer
      always_ff @(posedge CLK or negedge arstN) begin
         if (!arstN) begin
            cnt[t]      <= '0;
            zeroFlag[t] <= 1'b1;
         end else if (load[t]) begin
            cnt[t]      <= LoadVal[t];
            zeroFlag[t] <= 1'b0;
         end else if (!zeroFlag[t]) begin
            cnt[t]      <= cnt[t] - 1'b1;
            zeroFlag[t] <= (cnt[t] == CntW'(1));
         end
      end
   end

   assign readBlock   = ~zeroFlag[0];   // write was recent
   assign writeBlock  = ~zeroFlag[1];   // read was recent
   assign precharging = ~zeroFlag[2];

endmodule

`default_nettype wire

// File: src/cmdScheduler.sv
/*
  Request register and command FSM. Emits two command slots per CLK
  (memory clock is twice CLK). A refresh strobe wins over any issue.
  Refresh assumes an empty queue and all banks of the rank precharged.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module cmdScheduler import ddrPkg::*; (
   input  logic                   CLK,
   input  logic                   arstN,
   input  logic                   inhibit,
   input  logic                   refreshReq,
   input  logic [`DDR_RANK_W-1:0] refreshRank,
   input  logic                   empty,
   input  ddrReqT                 headReq,
   input  accessClassT            reqClass,
   input  logic                   readBlock,
   input  logic                   writeBlock,
   input  logic                   precharging,
   input  logic                   prechargeBlock,
   input  logic                   refreshBusy,
   input  logic                   fawBlock,
   output logic                   pop,
   output logic                   startRead,
   output logic                   startWrite,
   output logic                   actRank,
   output logic                   startPrecharge,
   output logic [`DDR_RANK_W-1:0] issueRank,
   output ddrCmdT                 cmd0,
   output ddrCmdT                 cmd1,
   output logic [`DDR_ROW_W-1:0]  cmdRow,
   output logic [`DDR_COL_W-1:0]  cmdCol,
   output logic [`DDR_BANK_W-1:0] cmdBank,
   output logic [`DDR_RANK_W-1:0] cmdRank
);

   typedef enum logic {stIdle, stAct} stateT;

   stateT  state;
   ddrReqT cur;                 // request register
   logic   curValid;
   ddrCmdT opCmd;
   logic   busBlock;
   logic   idleStall;
   logic   actStall;
   logic   issueIdle;
   logic   issueAct;
   logic   consume;

   assign opCmd     = cur.read ? cmdRead : cmdWrite;
   assign busBlock  = cur.read ? readBlock : writeBlock;
   assign issueRank = cur.rank;

   // ----------------------------------------
   // stall and issue
   always_comb begin
      idleStall = inhibit | refreshReq | refreshBusy;
      unique case (reqClass)
         accHit:  idleStall = idleStall | busBlock;
         accMiss: idleStall = idleStall | busBlock | fawBlock;
         default: idleStall = idleStall | prechargeBlock;   // bank must be done
      endcase
   end

   assign actStall  = inhibit | refreshReq | refreshBusy | precharging | fawBlock | busBlock;
   assign issueIdle = curValid & (state == stIdle) & ~idleStall;
   assign issueAct  = curValid & (state == stAct) & ~actStall;
   assign consume   = (issueIdle & (reqClass != accConflict)) | issueAct;
   assign pop       = ~empty & ~inhibit & ~refreshReq & (~curValid | consume);

   assign startRead      = consume & cur.read;
   assign startWrite     = consume & ~cur.read;
   assign actRank        = (issueIdle & (reqClass == accMiss)) | issueAct;
   assign startPrecharge = issueIdle & (reqClass == accConflict);

   always_ff @(posedge CLK) begin
      if (pop) cur <= headReq;
   end

   // ----------------------------------------
   // FSM and command slots
   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         curValid <= 1'b0;
         state    <= stIdle;
         cmd0     <= cmdNop;
         cmd1     <= cmdNop;
      end else begin
         curValid <= pop | (curValid & ~consume);
         cmd0     <= cmdNop;
         cmd1     <= cmdNop;
         if (refreshReq) begin
            cmd0 <= cmdRefresh;
         end else if (issueAct) begin
            cmd0  <= cmdActivate;    // row opened after precharge
            cmd1  <= opCmd;
            state <= stIdle;
         end else if (issueIdle) begin
            unique case (reqClass)
               accHit: cmd1 <= opCmd;
               accMiss: begin
                  cmd0 <= cmdActivate;
                  cmd1 <= opCmd;
               end
               default: begin
                  cmd0  <= cmdPrecharge;
                  state <= stAct;
               end
            endcase
         end
      end
   end

   // address follows the command that issues
   always_ff @(posedge CLK) begin
      if (refreshReq) begin
         cmdRank <= refreshRank;
      end else if (issueIdle | issueAct) begin
         cmdRank <= cur.rank;
         cmdBank <= cur.bank;
         cmdCol  <= cur.col;
         cmdRow  <= startPrecharge ? '0 : cur.row;   // A10 low, single bank
      end
   end

endmodule

`default_nettype wire

// File: src/ddrCmdCtrl.sv
/*
  DDR2 command core top. One request per cycle is accepted while
  reqFull is low. Outputs are registered command slot pairs.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module ddrCmdCtrl import ddrPkg::*; (
   input  logic                   CLK,
   input  logic                   arstN,
   input  logic                   reqValid,
   input  logic                   reqRead,
   input  logic [`DDR_RANK_W-1:0] reqRank,
   input  logic [`DDR_ROW_W-1:0]  reqRow,
   input  logic [`DDR_BANK_W-1:0] reqBank,
   input  logic [`DDR_COL_W-1:0]  reqCol,
   output logic                   reqFull,
   input  logic                   refreshReq,
   input  logic [`DDR_RANK_W-1:0] refreshRank,
   input  logic                   inhibit,
   output ddrCmdT                 cmd0,
   output ddrCmdT                 cmd1,
   output logic [`DDR_ROW_W-1:0]  cmdRow,
   output logic [`DDR_COL_W-1:0]  cmdCol,
   output logic [`DDR_BANK_W-1:0] cmdBank,
   output logic [`DDR_RANK_W-1:0] cmdRank
);

   ddrReqT                 headReq;
   accessClassT            reqClass;
   logic                   empty, pop;
   logic                   startRead, startWrite, actRank, startPrecharge;
   logic [`DDR_RANK_W-1:0] issueRank;
   logic                   readBlock, writeBlock, precharging;
   logic                   prechargeBlock, refreshBusy, fawBlock;

   reqFifo uFifo (
      .CLK(CLK), .arstN(arstN), .push(reqValid),
      .wrData({reqRead, reqRank, reqRow, reqBank, reqCol}),
      .pop(pop), .rdData(headReq), .empty(empty), .full(reqFull));

   openBankTable uTable (
      .CLK(CLK), .arstN(arstN), .lookup(pop), .req(headReq),
      .clearRank(refreshReq), .clearRankSel(refreshRank), .reqClass(reqClass));

   rankTimers uRankTimers (
      .CLK(CLK), .arstN(arstN), .actRank(actRank), .actSel(issueRank),
      .readSel(issueRank), .writeSel(issueRank), .readGo(startRead), .writeGo(startWrite),
      .refreshGo(refreshReq), .refreshSel(refreshRank), .queryRank(issueRank),
      .prechargeBlock(prechargeBlock), .refreshBusy(refreshBusy), .fawBlock(fawBlock));

   busTurnTimers uBusTimers (
      .CLK(CLK), .arstN(arstN), .readGo(startRead), .writeGo(startWrite),
      .prechargeGo(startPrecharge), .readBlock(readBlock), .writeBlock(writeBlock),
      .precharging(precharging));

   cmdScheduler uSched (
      .CLK(CLK), .arstN(arstN), .inhibit(inhibit), .refreshReq(refreshReq),
      .refreshRank(refreshRank), .empty(empty), .headReq(headReq), .reqClass(reqClass),
      .readBlock(readBlock), .writeBlock(writeBlock), .precharging(precharging),
      .prechargeBlock(prechargeBlock), .refreshBusy(refreshBusy), .fawBlock(fawBlock),
      .pop(pop), .startRead(startRead), .startWrite(startWrite), .actRank(actRank),
      .startPrecharge(startPrecharge), .issueRank(issueRank), .cmd0(cmd0), .cmd1(cmd1),
      .cmdRow(cmdRow), .cmdCol(cmdCol), .cmdBank(cmdBank), .cmdRank(cmdRank));

endmodule

`default_nettype wire

// File: tests/clockGen.sv
/*
  Testbench clock and reset. 10 ns period, reset held low over
  three rising edges and released on a falling edge.
*/
`timescale 1ns/1ns
`default_nettype none

module clockGen (
   output logic CLK,
   output logic arstN
);

   initial begin
      CLK   = 1'b0;
      arstN = 1'b0;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      arstN = 1'b1;                 // release away from the active edge
   end

   always #5 CLK = ~CLK;

endmodule

`default_nettype wire

// File: tests/ddrCmdCtrlTb.sv
/*
  Directed testbench for the DDR2 command core. Gap checks assume the
  timing values of the config header. Refresh is only sent while the
  queue is empty, as the core requires.
*/
`timescale 1ns/1ns
`default_nettype none

`include "ddrTiming_cfg.svh"

module ddrCmdCtrlTb;

   // RAS CAS WE
   localparam logic [2:0] OpRefresh   = 3'b001;
   localparam logic [2:0] OpPrecharge = 3'b010;
   localparam logic [2:0] OpActivate  = 3'b011;
   localparam logic [2:0] OpWrite     = 3'b100;
   localparam logic [2:0] OpRead      = 3'b101;
   localparam logic [2:0] OpNop       = 3'b111;

   localparam int NumTests = 6;
   localparam int CmdWait  = 100;   // cycles allowed for one command
   localparam logic [`DDR_ROW_W-1:0] RowA = 'h0123;
   localparam logic [`DDR_ROW_W-1:0] RowB = 'h2a5c;
   localparam logic [`DDR_ROW_W-1:0] RowC = 'h1000;

   logic                   CLK;
   logic                   arstN;
   logic                   reqValid;
   logic                   reqRead;
   logic [`DDR_RANK_W-1:0] reqRank;
   logic [`DDR_ROW_W-1:0]  reqRow;
   logic [`DDR_BANK_W-1:0] reqBank;
   logic [`DDR_COL_W-1:0]  reqCol;
   logic                   reqFull;
   logic                   refreshReq;
   logic [`DDR_RANK_W-1:0] refreshRank;
   logic                   inhibit;
   logic [2:0]             cmd0;
   logic [2:0]             cmd1;
   logic [`DDR_ROW_W-1:0]  cmdRow;
   logic [`DDR_COL_W-1:0]  cmdCol;
   logic [`DDR_BANK_W-1:0] cmdBank;
   logic [`DDR_RANK_W-1:0] cmdRank;

   // log of every cycle with a non-Nop slot
   int                     logCyc[$];
   logic [2:0]             logCmd0[$];
   logic [2:0]             logCmd1[$];
   logic [`DDR_ROW_W-1:0]  logRow[$];
   logic [`DDR_COL_W-1:0]  logCol[$];
   logic [`DDR_BANK_W-1:0] logBank[$];
   logic [`DDR_RANK_W-1:0] logRank[$];

   int     cycle  = 0;
   int     seen   = 0;              // log entries already taken by tests
   int     checks = 0;
   int     errors = 0;
   integer seed;

   clockGen clkGen (.CLK(CLK), .arstN(arstN));

   ddrCmdCtrl uut (
      .CLK(CLK), .arstN(arstN), .reqValid(reqValid), .reqRead(reqRead),
      .reqRank(reqRank), .reqRow(reqRow), .reqBank(reqBank), .reqCol(reqCol),
      .reqFull(reqFull), .refreshReq(refreshReq), .refreshRank(refreshRank),
      .inhibit(inhibit), .cmd0(cmd0), .cmd1(cmd1), .cmdRow(cmdRow), .cmdCol(cmdCol),
      .cmdBank(cmdBank), .cmdRank(cmdRank));

   // ----------------------------------------
   // command monitor, falling edge
   always @(negedge CLK) begin
      cycle = cycle + 1;
      if (cmd0 !== OpNop || cmd1 !== OpNop) begin
         logCyc.push_back(cycle);
         logCmd0.push_back(cmd0);
         logCmd1.push_back(cmd1);
         logRow.push_back(cmdRow);
         logCol.push_back(cmdCol);
         logBank.push_back(cmdBank);
         logRank.push_back(cmdRank);
      end
   end

   task automatic checkVal(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
      end
   endtask

   task automatic reportProblem(input string msg);
      errors++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   task automatic sendReq(input logic rd, input logic [`DDR_RANK_W-1:0] rank,
                          input logic [`DDR_ROW_W-1:0] row,
                          input logic [`DDR_BANK_W-1:0] bank,
                          input logic [`DDR_COL_W-1:0] col);
      @(posedge CLK);
      reqValid <= 1'b1;
      reqRead  <= rd;
      reqRank  <= rank;
      reqRow   <= row;
      reqBank  <= bank;
      reqCol   <= col;
   endtask

   task automatic idleReq();
      @(posedge CLK);
      reqValid <= 1'b0;
   endtask

   // next unread log entry, -1 on timeout
   task automatic waitCmd(output int idx);
      int n;
      n = 0;
      while (logCyc.size() <= seen && n < CmdWait) begin
         @(posedge CLK);
         n++;
      end
      if (logCyc.size() > seen) begin
         idx = seen;
         seen++;
      end else begin
         idx = -1;
         reportProblem($sformatf("no command issued within %0d cycles", CmdWait));
      end
   endtask

   task automatic checkAccess(input int idx, input logic [2:0] exp0, input logic [2:0] exp1,
                              input logic [`DDR_ROW_W-1:0] row,
                              input logic [`DDR_COL_W-1:0] col,
                              input logic [`DDR_BANK_W-1:0] bank,
                              input logic [`DDR_RANK_W-1:0] rank);
      checkVal("cmd0", logCmd0[idx], exp0);
      checkVal("cmd1", logCmd1[idx], exp1);
      checkVal("cmdRow", logRow[idx], row);
      checkVal("cmdCol", logCol[idx], col);
      checkVal("cmdBank", logBank[idx], bank);
      checkVal("cmdRank", logRank[idx], rank);
   endtask

   // ----------------------------------------
   // directed tests
   task automatic resetState();
      checkVal("cmd0", cmd0, OpNop);
      checkVal("cmd1", cmd1, OpNop);
      checkVal("reqFull", reqFull, 1'b0);
   endtask

   task automatic missIdleBank();
      int i;
      sendReq(1'b1, 1'b0, RowA, 3'd2, 8'h10);
      idleReq();
      waitCmd(i);
      if (i < 0) return;
      checkAccess(i, OpActivate, OpRead, RowA, 8'h10, 3'd2, 1'b0);
   endtask

   task automatic rowHit();
      int i;
      int j;
      sendReq(1'b1, 1'b0, RowA, 3'd2, 8'h12);
      sendReq(1'b0, 1'b0, RowA, 3'd2, 8'h14);   // write right behind the read
      idleReq();
      waitCmd(i);
      if (i < 0) return;
      checkAccess(i, OpNop, OpRead, RowA, 8'h12, 3'd2, 1'b0);
      waitCmd(j);
      if (j < 0) return;
      checkAccess(j, OpNop, OpWrite, RowA, 8'h14, 3'd2, 1'b0);
      if (logCyc[j] - logCyc[i] < `DDR_T_RTW)
         reportProblem($sformatf("write came %0d cycles after a read", logCyc[j] - logCyc[i]));
   endtask

   task automatic rowConflict();
      int i;
      int j;
      sendReq(1'b1, 1'b0, RowB, 3'd2, 8'h20);
      idleReq();
      waitCmd(i);
      if (i < 0) return;
      checkVal("cmd0", logCmd0[i], OpPrecharge);   // close row A first
      checkVal("cmd1", logCmd1[i], OpNop);
      checkVal("cmdBank", logBank[i], 3'd2);
      checkVal("cmdRank", logRank[i], 1'b0);
      waitCmd(j);
      if (j < 0) return;
      checkAccess(j, OpActivate, OpRead, RowB, 8'h20, 3'd2, 1'b0);
      if (logCyc[j] - logCyc[i] < `DDR_T_RPA)
         reportProblem($sformatf("activate came %0d cycles after precharge",
                                 logCyc[j] - logCyc[i]));
   endtask

   task automatic writeToRead();
      int i;
      int j;
      sendReq(1'b0, 1'b0, RowB, 3'd2, 8'h24);
      sendReq(1'b1, 1'b0, RowB, 3'd2, 8'h28);
      idleReq();
      waitCmd(i);
      if (i < 0) return;
      checkAccess(i, OpNop, OpWrite, RowB, 8'h24, 3'd2, 1'b0);
      waitCmd(j);
      if (j < 0) return;
      checkAccess(j, OpNop, OpRead, RowB, 8'h28, 3'd2, 1'b0);
      if (logCyc[j] - logCyc[i] < `DDR_T_WTR)
         reportProblem($sformatf("read came %0d cycles after a write", logCyc[j] - logCyc[i]));
   endtask

   task automatic refreshAndFullQueue();
      int                    i;
      int                    refCyc;
      int                    actCyc[`DDR_FIFO_DEPTH];
      logic [`DDR_ROW_W-1:0] qRow[`DDR_FIFO_DEPTH];
      logic [`DDR_COL_W-1:0] qCol[`DDR_FIFO_DEPTH];
      @(posedge CLK);
      refreshReq  <= 1'b1;            // one-cycle strobe
      refreshRank <= 1'b0;
      @(posedge CLK);
      refreshReq  <= 1'b0;
      waitCmd(i);
      if (i < 0) return;
      checkVal("cmd0", logCmd0[i], OpRefresh);
      checkVal("cmd1", logCmd1[i], OpNop);
      checkVal("cmdRank", logRank[i], 1'b0);
      refCyc = logCyc[i];
      sendReq(1'b1, 1'b0, RowB, 3'd2, 8'h30);  // row B was open before refresh
      idleReq();
      waitCmd(i);
      if (i < 0) return;
      checkAccess(i, OpActivate, OpRead, RowB, 8'h30, 3'd2, 1'b0);
      if (logCyc[i] - refCyc < `DDR_T_RFC)
         reportProblem($sformatf("activate came %0d cycles after refresh", logCyc[i] - refCyc));

      // ----------------------------------------
      // fill the queue while inhibited
      @(posedge CLK);
      inhibit <= 1'b1;
      for (int k = 0; k < `DDR_FIFO_DEPTH; k++) begin
         qRow[k] = RowC + k;
         qCol[k] = 8'($random(seed));
         sendReq(1'b1, 1'b1, qRow[k], 3'(k), qCol[k]);
      end
      idleReq();
      @(negedge CLK);
      checkVal("reqFull", reqFull, 1'b1);
      repeat (4) @(posedge CLK);
      checkVal("commands while inhibited", logCyc.size(), seen);
      @(posedge CLK);
      inhibit <= 1'b0;
      for (int k = 0; k < `DDR_FIFO_DEPTH; k++) begin
         waitCmd(i);
         if (i < 0) return;
         checkAccess(i, OpActivate, OpRead, qRow[k], qCol[k], 3'(k), 1'b1);
         actCyc[k] = logCyc[i];
         if (k >= `DDR_FAW_ACTS && actCyc[k] - actCyc[k - `DDR_FAW_ACTS] < `DDR_T_FAW)
            reportProblem($sformatf("activate %0d broke the four-activate window", k));
      end
   endtask

   task automatic endRun();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   // ----------------------------------------
   // main sequence and watchdog
   initial begin
      seed        = 32'he2158a0c;
      reqValid    = 1'b0;
      reqRead     = 1'b0;
      reqRank     = '0;
      reqRow      = '0;
      reqBank     = '0;
      reqCol      = '0;
      refreshReq  = 1'b0;
      refreshRank = '0;
      inhibit     = 1'b0;
      @(posedge arstN);
      resetState();                 // outputs still hold their reset values
      missIdleBank();
      rowHit();
      rowConflict();
      writeToRead();
      refreshAndFullQueue();
      repeat (5) @(posedge CLK);
      endRun();
   end

   initial begin
      repeat (NumTests * 200) @(posedge CLK);
      reportProblem($sformatf("watchdog expired after %0d cycles", NumTests * 200));
      endRun();
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
src/ddrPkg.sv
src/reqFifo.sv
src/openBankTable.sv
src/rankTimers.sv
src/busTurnTimers.sv
src/cmdScheduler.sv
src/ddrCmdCtrl.sv
tests/clockGen.sv
tests/ddrCmdCtrlTb.sv
